// ==== src/latency_pkg.sv ====
// Widths, settings register offsets, reset values, settings struct and FSM state enums
package latency_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int DATA_W     = 32;
  localparam int TIME_W     = 64;
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam int RB_W       = 64;

  // Returned for any readback address outside the register map
  localparam logic [RB_W-1:0] RB_DEFAULT = 64'h0BAD_C0DE_0BAD_C0DE;

  ////////////////////////////////////////////////////////////////////////////
  // Settings register map
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [SET_ADDR_W-1:0] {
    OFF_SPP_SHIFT      = 8'd0,
    OFF_WINDOW_LIMIT   = 8'd1,
    OFF_WINDOW_PACKETS = 8'd2,
    OFF_PACKET_SHIFT   = 8'd3
  } reg_offset_e;

  localparam logic [SET_DATA_W-1:0] RST_SPP_SHIFT      = 32'd16;
  localparam logic [SET_DATA_W-1:0] RST_WINDOW_LIMIT   = 32'd10000;
  localparam logic [SET_DATA_W-1:0] RST_WINDOW_PACKETS = 32'd16;
  localparam logic [SET_DATA_W-1:0] RST_PACKET_SHIFT   = 32'd4;

  // Only the low 6 bits of the shift settings are used
  typedef struct packed {
    logic [SET_DATA_W-1:0] spp_shift;
    logic [SET_DATA_W-1:0] window_limit;
    logic [SET_DATA_W-1:0] window_packets;
    logic [SET_DATA_W-1:0] packet_shift;
  } cfg_t;

  ////////////////////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic {
    ST_COUNTING = 1'b0,
    ST_STOPPED  = 1'b1
  } track_state_e;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SAMPLE = 2'd1,
    ST_PACKET = 2'd2
  } send_state_e;

endpackage

// ==== src/in_tap_if.sv ====
// Interface for the accepted input beat, shared by the tracker, accumulator and sender
`timescale 1ns/1ps

interface in_tap_if;

  // Handshake of the input stream
  logic valid;
  logic ready;
  logic last;

  // Per-beat timestamp and the free-running time beside it
  logic [latency_pkg::TIME_W-1:0] stamp;
  logic [latency_pkg::TIME_W-1:0] now;

  // The sender owns ready
  modport gate (
    output ready,
    input  valid,
    input  last
  );

  // Observers see the whole beat
  modport monitor (
    input valid,
    input ready,
    input last,
    input stamp,
    input now
  );

endinterface

// ==== src/latency_config_regs.sv ====
// Settings registers, write decode, registered readback mux and restart pulse
`timescale 1ns/1ps

module latency_config_regs #(
  parameter int REG_BASE = 128
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_set_stb,
  input  logic [latency_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [latency_pkg::SET_DATA_W-1:0]  i_set_data,
  input  logic [latency_pkg::SET_ADDR_W-1:0]  i_rb_addr,
  output logic [latency_pkg::RB_W-1:0]        o_rb_data,
  output latency_pkg::cfg_t                   o_cfg,
  output logic                                o_restart
);

  localparam logic [latency_pkg::SET_ADDR_W-1:0] BASE_ADDR =
    latency_pkg::SET_ADDR_W'(REG_BASE);

  // Distance of the write address from the register base
  logic [latency_pkg::SET_ADDR_W-1:0] addr_delta;

  assign addr_delta = i_set_addr - BASE_ADDR;

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      o_cfg.spp_shift      <= latency_pkg::RST_SPP_SHIFT;
      o_cfg.window_limit   <= latency_pkg::RST_WINDOW_LIMIT;
      o_cfg.window_packets <= latency_pkg::RST_WINDOW_PACKETS;
      o_cfg.packet_shift   <= latency_pkg::RST_PACKET_SHIFT;
    end else if (i_set_stb && (i_set_addr >= BASE_ADDR)) begin
      case (latency_pkg::reg_offset_e'(addr_delta))
        latency_pkg::OFF_SPP_SHIFT:      o_cfg.spp_shift      <= i_set_data;
        latency_pkg::OFF_WINDOW_LIMIT:   o_cfg.window_limit   <= i_set_data;
        latency_pkg::OFF_WINDOW_PACKETS: o_cfg.window_packets <= i_set_data;
        latency_pkg::OFF_PACKET_SHIFT:   o_cfg.packet_shift   <= i_set_data;
        default: begin
          // Outside the map, nothing changes
        end
      endcase
    end
  end

  // Any strobe restarts the measurement, whatever the address
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      o_restart <= 1'b0;
    end else begin
      o_restart <= i_set_stb;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////////////////////
  // Offsets here are relative, not based at REG_BASE
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      o_rb_data <= '0;
    end else begin
      case (latency_pkg::reg_offset_e'(i_rb_addr))
        latency_pkg::OFF_SPP_SHIFT:      o_rb_data <= {32'd0, o_cfg.spp_shift};
        latency_pkg::OFF_WINDOW_LIMIT:   o_rb_data <= {32'd0, o_cfg.window_limit};
        latency_pkg::OFF_WINDOW_PACKETS: o_rb_data <= {32'd0, o_cfg.window_packets};
        latency_pkg::OFF_PACKET_SHIFT:   o_rb_data <= {32'd0, o_cfg.packet_shift};
        default:                         o_rb_data <= latency_pkg::RB_DEFAULT;
      endcase
    end
  end

endmodule

// ==== src/window_tracker.sv ====
// Packet and window counting, window-end pulse and stop state
`timescale 1ns/1ps

module window_tracker (
  input  logic              clk,
  input  logic              reset,
  in_tap_if.monitor         tap,
  input  latency_pkg::cfg_t i_cfg,
  input  logic              i_restart,
  output logic              o_window_end
);

  localparam latency_pkg::track_state_e START_STATE =
    (latency_pkg::RST_WINDOW_LIMIT == '0) ? latency_pkg::ST_STOPPED
                                          : latency_pkg::ST_COUNTING;

  latency_pkg::track_state_e state;

  logic        packet_end;
  logic [31:0] pkt_target;
  logic [31:0] pkt_count;
  logic [31:0] win_count;

  assign packet_end = tap.valid && tap.ready && tap.last;

  // A window of zero packets behaves like a window of one
  assign pkt_target = (i_cfg.window_packets == '0) ? 32'd1 : i_cfg.window_packets;

  ////////////////////////////////////////////////////////////////////////////
  // Counting and stop control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state        <= START_STATE;
      pkt_count    <= '0;
      win_count    <= '0;
      o_window_end <= 1'b0;
    end else begin
      o_window_end <= 1'b0;
      if (i_restart) begin
        pkt_count <= '0;
        win_count <= '0;
        // New limit is already in place on the restart cycle
        state     <= (i_cfg.window_limit == '0) ? latency_pkg::ST_STOPPED
                                                : latency_pkg::ST_COUNTING;
      end else if ((state == latency_pkg::ST_COUNTING) && packet_end) begin
        if ((pkt_count + 32'd1) >= pkt_target) begin
          pkt_count    <= '0;
          win_count    <= win_count + 32'd1;
          o_window_end <= 1'b1;
          if ((win_count + 32'd1) >= i_cfg.window_limit) begin
            state <= latency_pkg::ST_STOPPED;
          end
        end else begin
          pkt_count <= pkt_count + 32'd1;
        end
      end
      // Stopped: beats pass, nothing is counted
    end
  end

endmodule

// ==== src/latency_accumulator.sv ====
// Per-packet latency and window sum
`timescale 1ns/1ps

module latency_accumulator (
  input  logic                            clk,
  input  logic                            reset,
  in_tap_if.monitor                       tap,
  input  logic                            i_restart,
  input  logic                            i_clear,
  output logic [latency_pkg::TIME_W-1:0]  o_sum
);

  logic                           packet_end;
  logic [latency_pkg::TIME_W-1:0] latency;

  assign packet_end = tap.valid && tap.ready && tap.last;

  // Wraps modulo 2^64, like the time base itself
  assign latency = tap.now - tap.stamp;

  ////////////////////////////////////////////////////////////////////////////
  // Window sum
  ////////////////////////////////////////////////////////////////////////////
  // Clear comes from the sender while input ready is low,
  // so it never meets a packet end
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      o_sum <= '0;
    end else if (i_restart || i_clear) begin
      o_sum <= '0;
    end else if (packet_end) begin
      o_sum <= o_sum + latency;
    end
  end

endmodule

// ==== src/report_sender.sv ====
// Window sum capture, average shifts, two-beat report FSM and input ready
`timescale 1ns/1ps

module report_sender (
  input  logic                            clk,
  input  logic                            reset,
  in_tap_if.gate                          tap,
  input  latency_pkg::cfg_t               i_cfg,
  input  logic                            i_window_end,
  input  logic [latency_pkg::TIME_W-1:0]  i_sum,
  output logic                            o_clear,
  output logic                            o_out_valid,
  input  logic                            i_out_ready,
  output logic [latency_pkg::DATA_W-1:0]  o_out_data,
  output logic                            o_out_last
);

  latency_pkg::send_state_e state;

  logic                           capture;
  logic [5:0]                     packet_shift;
  logic [6:0]                     sample_shift;
  logic [latency_pkg::TIME_W-1:0] sample_full;
  logic [latency_pkg::TIME_W-1:0] packet_full;
  logic [latency_pkg::DATA_W-1:0] sample_avg;
  logic [latency_pkg::DATA_W-1:0] packet_avg;

  // Window end only arrives while idle, ready was high on the closing beat
  assign capture = i_window_end && (state == latency_pkg::ST_IDLE);
  assign o_clear = capture;

  ////////////////////////////////////////////////////////////////////////////
  // Averages
  ////////////////////////////////////////////////////////////////////////////
  assign packet_shift = i_cfg.packet_shift[5:0];
  assign sample_shift = {1'b0, packet_shift} + {1'b0, i_cfg.spp_shift[5:0]};

  // Combined shift of 64 or more leaves nothing
  assign sample_full = sample_shift[6] ? '0 : (i_sum >> sample_shift[5:0]);
  assign packet_full = i_sum >> packet_shift;

  always_ff @(posedge clk) begin
    if (capture) begin
      sample_avg <= sample_full[latency_pkg::DATA_W-1:0];
      packet_avg <= packet_full[latency_pkg::DATA_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Report FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= latency_pkg::ST_IDLE;
    end else begin
      case (state)
        latency_pkg::ST_IDLE: begin
          if (capture) begin
            state <= latency_pkg::ST_SAMPLE;
          end
        end
        latency_pkg::ST_SAMPLE: begin
          if (i_out_ready) begin
            state <= latency_pkg::ST_PACKET;
          end
        end
        latency_pkg::ST_PACKET: begin
          if (i_out_ready) begin
            state <= latency_pkg::ST_IDLE;
          end
        end
        default: state <= latency_pkg::ST_IDLE;
      endcase
    end
  end

  assign o_out_valid = (state != latency_pkg::ST_IDLE);
  assign o_out_last  = (state == latency_pkg::ST_PACKET);

  always_comb begin
    case (state)
      latency_pkg::ST_SAMPLE: o_out_data = sample_avg;
      latency_pkg::ST_PACKET: o_out_data = packet_avg;
      default:                o_out_data = '0;
    endcase
  end

  // Hold off input from the window end until the report has gone out
  assign tap.ready = (state == latency_pkg::ST_IDLE) && !i_window_end;

endmodule

// ==== src/latency_report_top.sv ====
// Packet latency meter top level with plain ports and sub-block wiring
`timescale 1ns/1ps

module latency_report_top #(
  parameter int REG_BASE = 128
) (
  input  logic                                clk,
  input  logic                                reset,
  // Input sample stream
  input  logic                                i_in_valid,
  output logic                                o_in_ready,
  input  logic [latency_pkg::DATA_W-1:0]      i_in_data,
  input  logic                                i_in_last,
  input  logic [latency_pkg::TIME_W-1:0]      i_in_stamp,
  input  logic [latency_pkg::TIME_W-1:0]      i_now,
  // Report stream
  output logic                                o_out_valid,
  input  logic                                i_out_ready,
  output logic [latency_pkg::DATA_W-1:0]      o_out_data,
  output logic                                o_out_last,
  // Settings bus and readback
  input  logic                                i_set_stb,
  input  logic [latency_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [latency_pkg::SET_DATA_W-1:0]  i_set_data,
  input  logic [latency_pkg::SET_ADDR_W-1:0]  i_rb_addr,
  output logic [latency_pkg::RB_W-1:0]        o_rb_data
);

  latency_pkg::cfg_t              cfg;
  logic                           restart;
  logic                           window_end;
  logic                           clear;
  logic [latency_pkg::TIME_W-1:0] sum;

  // Sample payload is carried but never measured, i_in_data stays unconnected
  in_tap_if tap_i ();

  assign tap_i.valid = i_in_valid;
  assign tap_i.last  = i_in_last;
  assign tap_i.stamp = i_in_stamp;
  assign tap_i.now   = i_now;
  assign o_in_ready  = tap_i.ready;

  latency_config_regs #(
    .REG_BASE (REG_BASE)
  ) config_regs_i (
    .clk        (clk),
    .reset      (reset),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .o_cfg      (cfg),
    .o_restart  (restart)
  );

  window_tracker tracker_i (
    .clk          (clk),
    .reset        (reset),
    .tap          (tap_i.monitor),
    .i_cfg        (cfg),
    .i_restart    (restart),
    .o_window_end (window_end)
  );

  latency_accumulator accumulator_i (
    .clk       (clk),
    .reset     (reset),
    .tap       (tap_i.monitor),
    .i_restart (restart),
    .i_clear   (clear),
    .o_sum     (sum)
  );

  report_sender sender_i (
    .clk          (clk),
    .reset        (reset),
    .tap          (tap_i.gate),
    .i_cfg        (cfg),
    .i_window_end (window_end),
    .i_sum        (sum),
    .o_clear      (clear),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready),
    .o_out_data   (o_out_data),
    .o_out_last   (o_out_last)
  );

endmodule

// ==== include/latency_tb_model.svh ====
// Reference model of the meter, typed compare tasks and bounded wait helpers

////////////////////////////////////////////////////////////////////////////
// Model state, settings start at their reset values
////////////////////////////////////////////////////////////////////////////
logic [31:0] m_spp_shift      = 32'd16;
logic [31:0] m_window_limit   = 32'd10000;
logic [31:0] m_window_packets = 32'd16;
logic [31:0] m_packet_shift   = 32'd4;
logic [63:0] m_sum            = 64'd0;
int unsigned m_pkts           = 0;
int unsigned m_wins           = 0;
bit          m_stopped        = 1'b0;

// Expected report beats as {last, data}
logic [32:0] exp_q[$];
bit          out_busy     = 1'b0;
int unsigned close_edge   = 0;
int unsigned edge_count   = 0;
int unsigned reports_seen = 0;

function automatic logic [31:0] shifted_avg(input logic [63:0] sum, input int amount);
  logic [63:0] full;
  if (amount >= 64) begin
    full = 64'd0;
  end else begin
    full = sum >> amount;
  end
  return full[31:0];
endfunction

// Any settings strobe restarts, a hit in the map also loads the register
function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
  int offset;
  offset = int'(addr) - REG_BASE;
  case (offset)
    0: m_spp_shift      = data;
    1: m_window_limit   = data;
    2: m_window_packets = data;
    3: m_packet_shift   = data;
    default: begin
    end
  endcase
  m_sum     = 64'd0;
  m_pkts    = 0;
  m_wins    = 0;
  m_stopped = (m_window_limit == 32'd0);
endfunction

function automatic void model_packet_end(input logic [63:0] stamp, input logic [63:0] now,
                                         input int unsigned at_edge);
  logic [31:0] target;
  int          pshift;
  int          total;
  if (!m_stopped) begin
    m_sum  = m_sum + (now - stamp);
    target = (m_window_packets == 32'd0) ? 32'd1 : m_window_packets;
    m_pkts++;
    if (m_pkts >= target) begin
      pshift = int'(m_packet_shift[5:0]);
      total  = pshift + int'(m_spp_shift[5:0]);
      exp_q.push_back({1'b0, shifted_avg(m_sum, total)});
      exp_q.push_back({1'b1, shifted_avg(m_sum, pshift)});
      m_sum      = 64'd0;
      m_pkts     = 0;
      m_wins++;
      m_stopped  = (m_wins >= m_window_limit);
      out_busy   = 1'b1;
      close_edge = at_edge;
    end
  end
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////
task automatic check_beat(input logic [latency_pkg::DATA_W-1:0] got_data, input logic got_last,
                          input logic [latency_pkg::DATA_W-1:0] exp_data, input logic exp_last);
  if (got_data !== exp_data) begin
    stop_with_failure($sformatf("ERROR t=%0t o_out_data got 0x%08h expected 0x%08h",
                                $time, got_data, exp_data));
  end else if (got_last !== exp_last) begin
    stop_with_failure($sformatf("ERROR t=%0t o_out_last got %0b expected %0b",
                                $time, got_last, exp_last));
  end
endtask

task automatic check_readback(input logic [latency_pkg::RB_W-1:0] got,
                              input logic [latency_pkg::RB_W-1:0] expected);
  if (got !== expected) begin
    stop_with_failure($sformatf("ERROR t=%0t o_rb_data got 0x%016h expected 0x%016h",
                                $time, got, expected));
  end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
  if (got !== expected) begin
    stop_with_failure($sformatf("ERROR t=%0t %s got %0b expected %0b",
                                $time, name, got, expected));
  end
endtask

task automatic expect_report_beat(input logic [31:0] got_data, input logic got_last);
  logic [32:0] front;
  if (exp_q.size() == 0) begin
    stop_with_failure("A report beat was accepted while no beat was expected");
  end else begin
    front = exp_q.pop_front();
    check_beat(got_data, got_last, front[31:0], front[32]);
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Wait helpers
////////////////////////////////////////////////////////////////////////////
task automatic wait_reports_done();
  int waited;
  waited = 0;
  while ((exp_q.size() != 0) || out_busy || o_out_valid) begin
    @(negedge clk);
    waited++;
    if (waited > REPORT_TIMEOUT) begin
      stop_with_failure("Timed out waiting for the expected report beats");
    end
  end
endtask

// The monitor flags any report that shows up here
task automatic idle_cycles(input int cycles);
  for (int c = 0; c < cycles; c++) begin
    @(negedge clk);
  end
endtask

// ==== testbench/tb_latency_report.sv ====
// Testbench top with clock, reset, seeded random stimulus, monitor and test scenarios
`timescale 1ns/1ps

module tb_latency_report;

  localparam int REG_BASE       = 128;
  localparam int BEAT_TIMEOUT   = 400;
  localparam int REPORT_TIMEOUT = 2000;

  logic                               clk = 1'b0;
  logic                               reset;
  logic                               i_in_valid;
  logic                               o_in_ready;
  logic [latency_pkg::DATA_W-1:0]     i_in_data;
  logic                               i_in_last;
  logic [latency_pkg::TIME_W-1:0]     i_in_stamp;
  logic [latency_pkg::TIME_W-1:0]     i_now = 64'd1000000;
  logic                               o_out_valid;
  logic                               i_out_ready = 1'b1;
  logic [latency_pkg::DATA_W-1:0]     o_out_data;
  logic                               o_out_last;
  logic                               i_set_stb;
  logic [latency_pkg::SET_ADDR_W-1:0] i_set_addr;
  logic [latency_pkg::SET_DATA_W-1:0] i_set_data;
  logic [latency_pkg::SET_ADDR_W-1:0] i_rb_addr;
  logic [latency_pkg::RB_W-1:0]       o_rb_data;

  bit                                 backpressure;
  bit                                 valid_seen;
  bit                                 beat_held;
  logic [latency_pkg::DATA_W-1:0]     held_data;
  logic                               held_last;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "latency_tb_model.svh"

  latency_report_top #(.REG_BASE(REG_BASE)) dut_i (
    .clk (clk), .reset (reset),
    .i_in_valid (i_in_valid), .o_in_ready (o_in_ready), .i_in_data (i_in_data),
    .i_in_last (i_in_last), .i_in_stamp (i_in_stamp), .i_now (i_now),
    .o_out_valid (o_out_valid), .i_out_ready (i_out_ready),
    .o_out_data (o_out_data), .o_out_last (o_out_last),
    .i_set_stb (i_set_stb), .i_set_addr (i_set_addr), .i_set_data (i_set_data),
    .i_rb_addr (i_rb_addr), .o_rb_data (o_rb_data)
  );

  always #2 clk = ~clk;

  // Time base and output stalls
  always @(negedge clk) begin
    i_now <= i_now + 64'd1;
    i_out_ready <= backpressure ? (($urandom % 3) != 0) : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sees pre-edge values at each rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      edge_count++;
      if (out_busy) check_flag("o_in_ready", o_in_ready, 1'b0);
      if (o_out_valid) begin
        if (!valid_seen && !out_busy) begin
          stop_with_failure("A report appeared although no window was closed");
        end else if (!valid_seen && (edge_count != close_edge + 2)) begin
          stop_with_failure($sformatf("Report began %0d cycles after the closing packet, not 2",
                                      edge_count - close_edge));
        end
        if (beat_held) check_beat(o_out_data, o_out_last, held_data, held_last);
        if (i_out_ready) begin
          expect_report_beat(o_out_data, o_out_last);
          if (o_out_last) begin
            out_busy = 1'b0;
            reports_seen++;
          end
          beat_held = 1'b0;
        end else begin
          beat_held = 1'b1;
          held_data = o_out_data;
          held_last = o_out_last;
        end
      end else if (beat_held) begin
        stop_with_failure("o_out_valid dropped before the report beat was accepted");
      end
      valid_seen = o_out_valid;
      if (i_set_stb) model_write(i_set_addr, i_set_data);
      if (i_in_valid && o_in_ready && i_in_last) model_packet_end(i_in_stamp, i_now, edge_count);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, all driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_beat(input logic last);
    int waited;
    bit taken;
    waited     = 0;
    i_in_valid = 1'b1;
    i_in_last  = last;
    i_in_data  = $urandom;
    i_in_stamp = i_now - 64'($urandom % 5001);
    // Ready only moves at rising edges, so this value holds at the next one
    taken      = o_in_ready;
    while (!taken) begin
      @(negedge clk);
      waited++;
      if (waited > BEAT_TIMEOUT) begin
        stop_with_failure("Timed out waiting for o_in_ready on an input beat");
      end
      taken = o_in_ready;
    end
    @(negedge clk);
    i_in_valid = 1'b0;
    i_in_last  = 1'b0;
  endtask

  // Random packet lengths of 1 to 4 beats with short valid gaps
  task automatic run_packets(input int packets);
    int beats;
    for (int p = 0; p < packets; p++) begin
      beats = 1 + int'($urandom % 4);
      for (int b = 0; b < beats; b++) begin
        idle_cycles(int'($urandom % 3));
        send_beat(b == beats - 1);
      end
    end
  endtask

  task automatic write_setting(input int offset, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = latency_pkg::SET_ADDR_W'(REG_BASE + offset);
    i_set_data = data;
    @(negedge clk);
    i_set_stb  = 1'b0;
    // Restart has passed by the next falling edge
    @(negedge clk);
  endtask

  task automatic configure(input logic [31:0] spp, input logic [31:0] limit,
                           input logic [31:0] packets, input logic [31:0] pshift);
    write_setting(0, spp);
    write_setting(1, limit);
    write_setting(2, packets);
    write_setting(3, pshift);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [63:0] expected);
    i_rb_addr = addr;
    @(negedge clk);
    check_readback(o_rb_data, expected);
  endtask

  initial begin
    logic [31:0] wr_data [4];
    int unsigned base_reports;
    void'($urandom(32'h89b5));
    reset        = 1'b0;
    i_in_valid   = 1'b0;
    i_in_data    = '0;
    i_in_last    = 1'b0;
    i_in_stamp   = '0;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_rb_addr    = '0;
    backpressure = 1'b0;
    repeat (16) @(negedge clk);
    check_flag("o_out_valid", o_out_valid, 1'b0);
    check_flag("o_out_last", o_out_last, 1'b0);
    check_flag("o_in_ready", o_in_ready, 1'b1);
    check_readback(o_rb_data, 64'd0);
    reset = 1'b1;

    // Register map after reset, then random writes
    read_check(8'd0, 64'd16);
    read_check(8'd1, 64'd10000);
    read_check(8'd2, 64'd16);
    read_check(8'd3, 64'd4);
    read_check(8'd4, 64'h0BAD_C0DE_0BAD_C0DE);
    read_check(8'd255, 64'h0BAD_C0DE_0BAD_C0DE);
    for (int k = 0; k < 4; k++) begin
      wr_data[k] = $urandom;
      write_setting(k, wr_data[k]);
    end
    write_setting(7, $urandom);
    for (int k = 0; k < 4; k++) begin
      read_check(8'(k), {32'd0, wr_data[k]});
    end

    // Small windows with random shifts, one round with the shift past 63
    for (int round = 0; round < 3; round++) begin
      configure((round == 2) ? 32'd60 : ($urandom % 6), 32'd10000,
                1 + ($urandom % 5), (round == 2) ? (4 + ($urandom % 4)) : ($urandom % 8));
      run_packets(12);
      wait_reports_done();
    end

    // Output stalls
    backpressure = 1'b1;
    configure(32'd2, 32'd10000, 32'd2, 32'd1);
    run_packets(16);
    wait_reports_done();
    backpressure = 1'b0;

    // Report limit of three
    configure(32'd3, 32'd3, 32'd2, 32'd2);
    base_reports = reports_seen;
    run_packets(12);
    wait_reports_done();
    run_packets(4);
    idle_cycles(200);
    if (reports_seen - base_reports != 3) begin
      stop_with_failure($sformatf("Saw %0d reports with a limit of 3", reports_seen - base_reports));
    end

    // Restart in the middle of a window
    configure(32'd1, 32'd2, 32'd3, 32'd0);
    base_reports = reports_seen;
    run_packets(3);
    wait_reports_done();
    run_packets(2);
    write_setting(1, 32'd2);
    run_packets(6);
    wait_reports_done();
    run_packets(3);
    idle_cycles(200);
    if (reports_seen - base_reports != 3) begin
      stop_with_failure($sformatf("Saw %0d reports around the restart, not 3",
                                  reports_seen - base_reports));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+include
src/latency_pkg.sv
src/in_tap_if.sv
src/latency_config_regs.sv
src/window_tracker.sv
src/latency_accumulator.sv
src/report_sender.sv
src/latency_report_top.sv
testbench/tb_latency_report.sv

// ==== Makefile ====
# Verilator build and run for the packet latency meter

VERILATOR ?= verilator
TOP       ?= tb_latency_report
RTL_TOP   ?= latency_report_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
